// ==== Bender.yml ====
package:
  name: stw_systolic

sources:
  - include_dirs:
      - design
    files:
      - design/systolic_pkg.sv
      - design/stw_pkg.sv
      - design/mac_pe.sv
      - design/systolic_array.sv
      - design/stw_controller.sv
      - design/stw_systolic_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_stw_systolic.sv

// ==== design/mac_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_consts.svh"

module mac_pe (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    stall,
    input  wire systolic_pkg::pe_mode_t mode,
    input  wire stw_pkg::fault_code_t   fault,
    input  wire                    stw_start,
    input  wire systolic_pkg::word_t    left_in,
    input  wire systolic_pkg::word_t    top_in,
    output systolic_pkg::word_t         right_out,
    output systolic_pkg::word_t         bottom_out,
    output logic                   stw_result,
    output logic                   stw_complete
);

    // stationary operand
    systolic_pkg::word_t weight;

    // shared MAC datapath
    systolic_pkg::word_t mul_a;
    systolic_pkg::word_t mul_b;
    systolic_pkg::word_t add_b;
    systolic_pkg::word_t product;
    systolic_pkg::word_t product_f;
    systolic_pkg::word_t sum;
    systolic_pkg::word_t sum_f;
    logic                data_en;

    // self-test borrows the multiplier and adder for one cycle
    assign mul_a = stw_start ? systolic_pkg::word_t'(`STW_OP1) : left_in;
    assign mul_b = stw_start ? systolic_pkg::word_t'(`STW_OP2) : weight;
    assign add_b = stw_start ? systolic_pkg::word_t'(`STW_ADD) : top_in;

    // wraps to WORD_SIZE
    assign product = mul_a * mul_b;

    // fault at the multiplier output
    always_comb begin
        product_f = product;
        case (fault)
            stw_pkg::FAULT_PROD_ZERO: product_f = '0;
            stw_pkg::FAULT_PROD_LSB:  product_f[0] = ~product[0];
            default:                  product_f = product;
        endcase
    end

    assign sum = product_f + add_b;

    // fault at the adder output
    always_comb begin
        sum_f = sum;
        if (fault == stw_pkg::FAULT_SUM_MSB) begin
            sum_f[`WORD_SIZE-1] = ~sum[`WORD_SIZE-1];
        end
    end

    // the world stops while the self-test owns the datapath
    assign data_en = !stall && !stw_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            weight     <= '0;
            right_out  <= '0;
            bottom_out <= '0;
        end else if (data_en) begin
            case (mode)
                systolic_pkg::PE_LOAD: begin
                    weight     <= top_in;
                    bottom_out <= top_in;
                end
                systolic_pkg::PE_COMPUTE: begin
                    right_out  <= left_in;
                    bottom_out <= sum_f;
                end
                default: begin
                    weight <= weight;
                end
            endcase
        end
    end

    // self-test checker sets its bit on a mismatch
    always_ff @(posedge clk) begin
        if (rst) begin
            stw_result   <= 1'b0;
            stw_complete <= 1'b0;
        end else if (stw_start) begin
            stw_result   <= (sum_f != systolic_pkg::word_t'(`STW_EXPECTED));
            stw_complete <= 1'b1;
        end
    end

    a_mode_legal: assert property (
        @(posedge clk) disable iff (rst)
        mode inside {systolic_pkg::PE_HOLD, systolic_pkg::PE_LOAD, systolic_pkg::PE_COMPUTE}
    ) else $error("mac_pe: illegal mode encoding %0d", mode);

endmodule

`default_nettype wire

// ==== design/stw_consts.svh ====
`ifndef STW_CONSTS_SVH
`define STW_CONSTS_SVH

// array geometry
`define ARR_ROWS 4
`define ARR_COLS 4

// signed datapath word width
`define WORD_SIZE 16

// width of a per-element fault code
`define FAULT_BITS 2

// self-test case: op1 * op2 + add
`define STW_OP1 3
`define STW_OP2 5
`define STW_ADD 7

// 3 * 5 + 7
`define STW_EXPECTED 22

`endif

// ==== design/stw_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module stw_controller (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     stw_en,
    input  wire stw_pkg::pe_flags_t pe_complete,
    output logic                    stw_start,
    output logic                    stw_complete
);

    stw_pkg::stw_state_t state;
    stw_pkg::stw_state_t state_next;

    // one cycle of RUN per test, back to IDLE right after
    always_comb begin
        state_next = state;
        case (state)
            stw_pkg::STW_IDLE: begin
                if (stw_en) begin
                    state_next = stw_pkg::STW_RUN;
                end
            end
            stw_pkg::STW_RUN: begin
                state_next = stw_pkg::STW_IDLE;
            end
            default: begin
                state_next = stw_pkg::STW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stw_pkg::STW_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // start pulse covers the whole RUN cycle
    assign stw_start = (state == stw_pkg::STW_RUN);

    // every element must have finished
    assign stw_complete = &pe_complete;

    a_start_single: assert property (
        @(posedge clk) disable iff (rst)
        stw_start |=> !stw_start
    ) else $error("stw_controller: start pulse longer than one cycle");

    // the elements answer a start pulse at the very next edge
    a_start_completes: assert property (
        @(posedge clk) disable iff (rst)
        stw_start |=> stw_complete
    ) else $error("stw_controller: array did not report complete");

endmodule

`default_nettype wire

// ==== design/stw_pkg.sv ====
`default_nettype none

`include "stw_consts.svh"

package stw_pkg;

    // fault applied inside one element's MAC datapath
    typedef enum logic [`FAULT_BITS-1:0] {
        FAULT_NONE      = 2'd0,
        FAULT_PROD_ZERO = 2'd1,
        FAULT_PROD_LSB  = 2'd2,
        FAULT_SUM_MSB   = 2'd3
    } fault_code_t;

    // column-major with element (r, c) at c*ARR_ROWS + r
    typedef fault_code_t [`ARR_ROWS*`ARR_COLS-1:0] fault_map_t;
    typedef logic [`ARR_ROWS*`ARR_COLS-1:0] pe_flags_t;

    // self-test sequencer state
    typedef enum logic {
        STW_IDLE = 1'b0,
        STW_RUN  = 1'b1
    } stw_state_t;

endpackage

`default_nettype wire

// ==== design/stw_systolic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stw_systolic_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         stall,
    input  wire systolic_pkg::pe_mode_t mode,
    input  wire systolic_pkg::row_bus_t left_in,
    input  wire systolic_pkg::col_bus_t top_in,
    input  wire stw_pkg::fault_map_t    fault_inject,
    input  wire                         stw_en,
    output systolic_pkg::row_bus_t      right_out,
    output systolic_pkg::col_bus_t      bottom_out,
    output stw_pkg::pe_flags_t          stw_result,
    output logic                        stw_complete
);

    logic               stw_start;
    stw_pkg::pe_flags_t pe_complete;

    systolic_array i_array (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .mode         (mode),
        .fault_inject (fault_inject),
        .stw_start    (stw_start),
        .left_in      (left_in),
        .top_in       (top_in),
        .right_out    (right_out),
        .bottom_out   (bottom_out),
        .stw_result   (stw_result),
        .pe_complete  (pe_complete)
    );

    stw_controller i_stw_ctrl (
        .clk          (clk),
        .rst          (rst),
        .stw_en       (stw_en),
        .pe_complete  (pe_complete),
        .stw_start    (stw_start),
        .stw_complete (stw_complete)
    );

endmodule

`default_nettype wire

// ==== design/systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_consts.svh"

module systolic_array (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         stall,
    input  wire systolic_pkg::pe_mode_t mode,
    input  wire stw_pkg::fault_map_t    fault_inject,
    input  wire                         stw_start,
    input  wire systolic_pkg::row_bus_t left_in,
    input  wire systolic_pkg::col_bus_t top_in,
    output systolic_pkg::row_bus_t      right_out,
    output systolic_pkg::col_bus_t      bottom_out,
    output stw_pkg::pe_flags_t          stw_result,
    output stw_pkg::pe_flags_t          pe_complete
);

    // hor[r][c] feeds element (r, c) from the left, hor[r][ARR_COLS] is the right edge
    systolic_pkg::word_t hor [`ARR_ROWS][`ARR_COLS+1];

    // ver[r][c] feeds element (r, c) from above, ver[ARR_ROWS][c] is the bottom edge
    systolic_pkg::word_t ver [`ARR_ROWS+1][`ARR_COLS];

    genvar r;
    genvar c;

    generate
        for (r = 0; r < `ARR_ROWS; r++) begin : g_row_edge
            assign hor[r][0]    = left_in[r];
            assign right_out[r] = hor[r][`ARR_COLS];
        end

        for (c = 0; c < `ARR_COLS; c++) begin : g_col_edge
            assign ver[0][c]     = top_in[c];
            assign bottom_out[c] = ver[`ARR_ROWS][c];
        end

        for (r = 0; r < `ARR_ROWS; r++) begin : g_row
            for (c = 0; c < `ARR_COLS; c++) begin : g_col
                // flags and fault codes are column-major
                localparam int IDX = c * `ARR_ROWS + r;

                mac_pe i_pe (
                    .clk          (clk),
                    .rst          (rst),
                    .stall        (stall),
                    .mode         (mode),
                    .fault        (fault_inject[IDX]),
                    .stw_start    (stw_start),
                    .left_in      (hor[r][c]),
                    .top_in       (ver[r][c]),
                    .right_out    (hor[r][c+1]),
                    .bottom_out   (ver[r+1][c]),
                    .stw_result   (stw_result[IDX]),
                    .stw_complete (pe_complete[IDX])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== design/systolic_pkg.sv ====
`default_nettype none

`include "stw_consts.svh"

package systolic_pkg;

    // one signed datapath word
    typedef logic signed [`WORD_SIZE-1:0] word_t;

    // one word per row, used on the left and right edges
    typedef word_t [`ARR_ROWS-1:0] row_bus_t;

    // one word per column, used on the top and bottom edges
    typedef word_t [`ARR_COLS-1:0] col_bus_t;

    // element operating mode
    typedef enum logic [1:0] {
        PE_HOLD    = 2'd0,
        PE_LOAD    = 2'd1,
        PE_COMPUTE = 2'd2
    } pe_mode_t;

endpackage

`default_nettype wire

// ==== testbench/tb_stw_systolic.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_consts.svh"

module tb_stw_systolic;

    localparam int ROWS = `ARR_ROWS;
    localparam int COLS = `ARR_COLS;
    localparam int STREAM_LEN = 120;
    // three streams of about 130 cycles plus loads and self-tests, roughly four times over
    localparam int TIMEOUT_CYCLES = 2000;

    logic                   clk;
    logic                   rst;
    logic                   stall;
    systolic_pkg::pe_mode_t mode;
    systolic_pkg::row_bus_t left_in;
    systolic_pkg::col_bus_t top_in;
    stw_pkg::fault_map_t    fault_inject;
    logic                   stw_en;
    systolic_pkg::row_bus_t right_out;
    systolic_pkg::col_bus_t bottom_out;
    stw_pkg::pe_flags_t     stw_result;
    logic                   stw_complete;

    // fault map applied with the next driven cycle
    stw_pkg::fault_map_t faults;

    // reference model holding the state expected after the next sampling edge
    systolic_pkg::word_t m_weight [ROWS][COLS];
    systolic_pkg::word_t m_right  [ROWS][COLS];
    systolic_pkg::word_t m_bottom [ROWS][COLS];

    integer seed = 89;
    int     cycle_count = 0;
    int     checks = 0;
    int     errors = 0;

    stw_systolic_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .mode         (mode),
        .left_in      (left_in),
        .top_in       (top_in),
        .fault_inject (fault_inject),
        .stw_en       (stw_en),
        .right_out    (right_out),
        .bottom_out   (bottom_out),
        .stw_result   (stw_result),
        .stw_complete (stw_complete)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_col(input string name, input systolic_pkg::col_bus_t exp,
                             input systolic_pkg::col_bus_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_row(input string name, input systolic_pkg::row_bus_t exp,
                             input systolic_pkg::row_bus_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input stw_pkg::pe_flags_t exp,
                               input stw_pkg::pe_flags_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // one multiply-add with the element's fault applied
    function automatic systolic_pkg::word_t faulty_mac(input systolic_pkg::word_t a,
                                                       input systolic_pkg::word_t w,
                                                       input systolic_pkg::word_t t,
                                                       input stw_pkg::fault_code_t f);
        systolic_pkg::word_t p;
        systolic_pkg::word_t s;
        p = a * w;
        if (f == stw_pkg::FAULT_PROD_ZERO) begin
            p = '0;
        end
        if (f == stw_pkg::FAULT_PROD_LSB) begin
            p[0] = ~p[0];
        end
        s = p + t;
        if (f == stw_pkg::FAULT_SUM_MSB) begin
            s[`WORD_SIZE-1] = ~s[`WORD_SIZE-1];
        end
        return s;
    endfunction

    // a set bit where the fixed case misses 22
    function automatic stw_pkg::pe_flags_t expected_flags(input stw_pkg::fault_map_t fm);
        stw_pkg::pe_flags_t v;
        systolic_pkg::word_t res;
        for (int i = 0; i < ROWS * COLS; i++) begin
            res = faulty_mac(systolic_pkg::word_t'(`STW_OP1), systolic_pkg::word_t'(`STW_OP2),
                             systolic_pkg::word_t'(`STW_ADD), fm[i]);
            v[i] = (res != systolic_pkg::word_t'(`STW_EXPECTED));
        end
        return v;
    endfunction

    function automatic systolic_pkg::col_bus_t expected_bottom();
        systolic_pkg::col_bus_t v;
        for (int c = 0; c < COLS; c++) begin
            v[c] = m_bottom[ROWS-1][c];
        end
        return v;
    endfunction

    function automatic systolic_pkg::row_bus_t expected_right();
        systolic_pkg::row_bus_t v;
        for (int r = 0; r < ROWS; r++) begin
            v[r] = m_right[r][COLS-1];
        end
        return v;
    endfunction

    task automatic model_reset();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                m_weight[r][c] = '0;
                m_right[r][c]  = '0;
                m_bottom[r][c] = '0;
            end
        end
    endtask

    // every element moves at once, so new state is built from the old copy
    task automatic model_clock(input systolic_pkg::pe_mode_t md, input systolic_pkg::row_bus_t lin,
                               input systolic_pkg::col_bus_t tin, input logic stl,
                               input stw_pkg::fault_map_t fm);
        systolic_pkg::word_t nw [ROWS][COLS];
        systolic_pkg::word_t nr [ROWS][COLS];
        systolic_pkg::word_t nb [ROWS][COLS];
        systolic_pkg::word_t a;
        systolic_pkg::word_t t;
        nw = m_weight;
        nr = m_right;
        nb = m_bottom;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                a = (c == 0) ? lin[r] : m_right[r][c-1];
                t = (r == 0) ? tin[c] : m_bottom[r-1][c];
                if (!stl && md == systolic_pkg::PE_LOAD) begin
                    nw[r][c] = t;
                    nb[r][c] = t;
                end else if (!stl && md == systolic_pkg::PE_COMPUTE) begin
                    nr[r][c] = a;
                    nb[r][c] = faulty_mac(a, m_weight[r][c], t, fm[c*ROWS+r]);
                end
            end
        end
        m_weight = nw;
        m_right  = nr;
        m_bottom = nb;
    endtask

    // drive one cycle, then check what the previous cycle produced
    task automatic step(input string name, input systolic_pkg::pe_mode_t md,
                        input systolic_pkg::row_bus_t lin, input systolic_pkg::col_bus_t tin,
                        input logic stl);
        @(posedge clk);
        mode         <= md;
        left_in      <= lin;
        top_in       <= tin;
        stall        <= stl;
        fault_inject <= faults;
        stw_en       <= 1'b0;
        @(negedge clk);
        check_col({name, " bottom_out"}, expected_bottom(), bottom_out);
        check_row({name, " right_out"}, expected_right(), right_out);
        model_clock(md, lin, tin, stl, faults);
    endtask

    task automatic clear_faults();
        for (int i = 0; i < ROWS * COLS; i++) begin
            faults[i] = stw_pkg::FAULT_NONE;
        end
    endtask

    task automatic set_fault(input int r, input int c, input stw_pkg::fault_code_t code);
        faults[c*ROWS+r] = code;
    endtask

    task automatic load_weights(input string name);
        systolic_pkg::col_bus_t tin;
        for (int i = 0; i < ROWS; i++) begin
            for (int c = 0; c < COLS; c++) begin
                tin[c] = systolic_pkg::word_t'($random(seed));
            end
            step({name, " load"}, systolic_pkg::PE_LOAD, '0, tin, 1'b0);
        end
    endtask

    // skewed activations with row r starting r cycles late and an optional stall window
    task automatic stream(input string name, input int stall_at, input int stall_len);
        systolic_pkg::row_bus_t lin;
        systolic_pkg::row_bus_t held_r;
        systolic_pkg::col_bus_t held_b;
        for (int t = 0; t < STREAM_LEN + ROWS + COLS; t++) begin
            for (int r = 0; r < ROWS; r++) begin
                lin[r] = (t >= r && t < r + STREAM_LEN) ? systolic_pkg::word_t'($random(seed)) : '0;
            end
            if (stall_len > 0 && t == stall_at) begin
                for (int k = 0; k < stall_len; k++) begin
                    step({name, " stall"}, systolic_pkg::PE_COMPUTE, lin, '0, 1'b1);
                    if (k == 0) begin
                        held_b = expected_bottom();
                        held_r = expected_right();
                    end else begin
                        check_col({name, " hold bottom_out"}, held_b, bottom_out);
                        check_row({name, " hold right_out"}, held_r, right_out);
                    end
                end
            end
            step(name, systolic_pkg::PE_COMPUTE, lin, '0, 1'b0);
            if (stall_len > 0 && t == stall_at) begin
                // this edge still saw the last stalled cycle
                check_col({name, " hold bottom_out"}, held_b, bottom_out);
                check_row({name, " hold right_out"}, held_r, right_out);
            end
        end
    endtask

    // start pulse one edge after stw_en, results one edge later
    task automatic run_self_test(input string name);
        logic prev_complete;
        @(posedge clk);
        mode         <= systolic_pkg::PE_HOLD;
        stall        <= 1'b0;
        left_in      <= '0;
        top_in       <= '0;
        fault_inject <= faults;
        stw_en       <= 1'b1;
        @(negedge clk);
        prev_complete = stw_complete;
        @(posedge clk);
        stw_en <= 1'b0;
        @(negedge clk);
        check_bit({name, " complete after one edge"}, prev_complete, stw_complete);
        @(posedge clk);
        @(negedge clk);
        check_bit({name, " complete"}, 1'b1, stw_complete);
        check_flags({name, " result"}, expected_flags(faults), stw_result);
    endtask

    task automatic test_reset_values();
        @(negedge clk);
        check_col("reset bottom_out", '0, bottom_out);
        check_row("reset right_out", '0, right_out);
        check_flags("reset stw_result", '0, stw_result);
        check_bit("reset stw_complete", 1'b0, stw_complete);
    endtask

    task automatic test_fault_self_test();
        clear_faults();
        set_fault(0, 0, stw_pkg::FAULT_PROD_ZERO);
        set_fault(3, 2, stw_pkg::FAULT_PROD_ZERO);
        run_self_test("stw prod_zero");
        clear_faults();
        set_fault(1, 1, stw_pkg::FAULT_PROD_LSB);
        set_fault(2, 3, stw_pkg::FAULT_PROD_LSB);
        run_self_test("stw prod_lsb");
        clear_faults();
        set_fault(3, 0, stw_pkg::FAULT_SUM_MSB);
        set_fault(0, 3, stw_pkg::FAULT_SUM_MSB);
        run_self_test("stw sum_msb");
        // all three codes at once
        set_fault(2, 1, stw_pkg::FAULT_PROD_ZERO);
        set_fault(1, 2, stw_pkg::FAULT_PROD_LSB);
        run_self_test("stw mixed");
        clear_faults();
        run_self_test("stw cleared");
    endtask

    task automatic test_fault_compute();
        clear_faults();
        set_fault(1, 2, stw_pkg::FAULT_PROD_ZERO);
        load_weights("fault compute");
        stream("fault compute", -1, 0);
        clear_faults();
    endtask

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        stall = 1'b0;
        mode  = systolic_pkg::PE_HOLD;
        left_in = '0;
        top_in  = '0;
        stw_en  = 1'b0;
        clear_faults();
        fault_inject = faults;
        model_reset();

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_reset_values();
        run_self_test("stw clean");
        load_weights("compute");
        stream("compute", -1, 0);
        load_weights("stall");
        stream("stall", STREAM_LEN / 2, 3);
        test_fault_self_test();
        test_fault_compute();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/systolic_pkg.sv
design/stw_pkg.sv
design/mac_pe.sv
design/systolic_array.sv
design/stw_controller.sv
design/stw_systolic_top.sv
testbench/tb_stw_systolic.sv
